/* verilog/branch_pkg.sv */
package branch_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int word_w = 32;
    localparam int tag_w  = 2;
    localparam int op_w   = 4;

    localparam logic [word_w-1:0] inst_bytes = 32'd4; // PC step and link offset

    // ==============================
    // Source tags
    // ==============================
    localparam logic [tag_w-1:0] tag_unlocked = 2'd0; // Operand present
    localparam logic [tag_w-1:0] tag_alu0     = 2'd1;
    localparam logic [tag_w-1:0] tag_alu1     = 2'd2;
    localparam logic [tag_w-1:0] tag_ls       = 2'd3;

    // ==============================
    // Branch operation codes
    // ==============================
    localparam logic [op_w-1:0] op_beq  = 4'd0;
    localparam logic [op_w-1:0] op_bne  = 4'd1;
    localparam logic [op_w-1:0] op_blt  = 4'd2; // Signed
    localparam logic [op_w-1:0] op_bge  = 4'd3; // Signed
    localparam logic [op_w-1:0] op_bltu = 4'd4;
    localparam logic [op_w-1:0] op_bgeu = 4'd5;
    localparam logic [op_w-1:0] op_jal  = 4'd6;
    localparam logic [op_w-1:0] op_jalr = 4'd7;

    // Snoop the result buses for one tagged operand.
    // Result is {tag, data}; a matching broadcast unlocks the operand.
    function automatic logic [tag_w+word_w-1:0] capture_operand(
        input logic [tag_w-1:0]  tag,
        input logic [word_w-1:0] data,
        input logic              alu0_valid,
        input logic [word_w-1:0] alu0_data,
        input logic              alu1_valid,
        input logic [word_w-1:0] alu1_data,
        input logic              ls_valid,
        input logic [word_w-1:0] ls_data
    );
        logic [tag_w+word_w-1:0] result;
        result = {tag, data}; // Hold by default
        case (tag)
            tag_alu0: if (alu0_valid) result = {tag_unlocked, alu0_data};
            tag_alu1: if (alu1_valid) result = {tag_unlocked, alu1_data};
            tag_ls:   if (ls_valid)   result = {tag_unlocked, ls_data};
            default:  result = {tag, data};
        endcase
        return result;
    endfunction

endpackage

/* verilog/branch_issue_stage.sv */
module branch_issue_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [branch_pkg::word_w-1:0]   in_pc,
    input  logic [branch_pkg::op_w-1:0]     in_op,
    input  logic [branch_pkg::word_w-1:0]   in_imm,
    input  logic [branch_pkg::tag_w-1:0]    in_tag_x,
    input  logic [branch_pkg::tag_w-1:0]    in_tag_y,
    input  logic [branch_pkg::word_w-1:0]   in_data_x,
    input  logic [branch_pkg::word_w-1:0]   in_data_y,
    input  logic                            alu0_valid,
    input  logic [branch_pkg::word_w-1:0]   alu0_data,
    input  logic                            alu1_valid,
    input  logic [branch_pkg::word_w-1:0]   alu1_data,
    input  logic                            ls_valid,
    input  logic [branch_pkg::word_w-1:0]   ls_data,
    output logic                            iss_valid,
    input  logic                            iss_ready,
    output logic [branch_pkg::word_w-1:0]   iss_pc,
    output logic [branch_pkg::op_w-1:0]     iss_op,
    output logic [branch_pkg::word_w-1:0]   iss_imm,
    output logic [branch_pkg::tag_w-1:0]    iss_tag_x,
    output logic [branch_pkg::tag_w-1:0]    iss_tag_y,
    output logic [branch_pkg::word_w-1:0]   iss_data_x,
    output logic [branch_pkg::word_w-1:0]   iss_data_y
);

    logic                                        accept;
    logic [branch_pkg::tag_w+branch_pkg::word_w-1:0] next_x;
    logic [branch_pkg::tag_w+branch_pkg::word_w-1:0] next_y;

    assign in_ready = !iss_valid || iss_ready; // Empty or draining this cycle
    assign accept   = in_valid && in_ready;

    // New instruction or held one, both see this cycle's broadcasts
    always_comb begin
        if (accept) begin
            next_x = branch_pkg::capture_operand(in_tag_x, in_data_x, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
            next_y = branch_pkg::capture_operand(in_tag_y, in_data_y, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
        end else begin
            next_x = branch_pkg::capture_operand(iss_tag_x, iss_data_x, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
            next_y = branch_pkg::capture_operand(iss_tag_y, iss_data_y, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else if (accept) begin
            iss_valid <= 1'b1;
        end else if (iss_ready) begin
            iss_valid <= 1'b0; // Handed to station
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_pc  <= in_pc;
            iss_op  <= in_op;
            iss_imm <= in_imm;
        end
        {iss_tag_x, iss_data_x} <= next_x;
        {iss_tag_y, iss_data_y} <= next_y;
    end

endmodule

/* verilog/branch_station.sv */
module branch_station (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            iss_valid,
    output logic                            iss_ready,
    input  logic [branch_pkg::word_w-1:0]   iss_pc,
    input  logic [branch_pkg::op_w-1:0]     iss_op,
    input  logic [branch_pkg::word_w-1:0]   iss_imm,
    input  logic [branch_pkg::tag_w-1:0]    iss_tag_x,
    input  logic [branch_pkg::tag_w-1:0]    iss_tag_y,
    input  logic [branch_pkg::word_w-1:0]   iss_data_x,
    input  logic [branch_pkg::word_w-1:0]   iss_data_y,
    input  logic                            alu0_valid,
    input  logic [branch_pkg::word_w-1:0]   alu0_data,
    input  logic                            alu1_valid,
    input  logic [branch_pkg::word_w-1:0]   alu1_data,
    input  logic                            ls_valid,
    input  logic [branch_pkg::word_w-1:0]   ls_data,
    output logic                            ex_valid,
    input  logic                            ex_ready,
    output logic [branch_pkg::word_w-1:0]   ex_pc,
    output logic [branch_pkg::op_w-1:0]     ex_op,
    output logic [branch_pkg::word_w-1:0]   ex_imm,
    output logic [branch_pkg::word_w-1:0]   ex_x,
    output logic [branch_pkg::word_w-1:0]   ex_y
);

    // ==============================
    // Entry state
    // ==============================
    logic                            busy;
    logic [branch_pkg::tag_w-1:0]    tag_x;
    logic [branch_pkg::tag_w-1:0]    tag_y;
    logic [branch_pkg::word_w-1:0]   data_x;
    logic [branch_pkg::word_w-1:0]   data_y;

    logic                                            accept;
    logic                                            release_entry;
    logic [branch_pkg::tag_w+branch_pkg::word_w-1:0] next_x;
    logic [branch_pkg::tag_w+branch_pkg::word_w-1:0] next_y;

    // Ready to execute once nothing is still tagged
    assign ex_valid = busy && (tag_x == branch_pkg::tag_unlocked)
                           && (tag_y == branch_pkg::tag_unlocked);

    assign release_entry = ex_valid && ex_ready;
    assign iss_ready     = !busy || release_entry; // Refill on the same edge
    assign accept        = iss_valid && iss_ready;

    assign ex_x = data_x;
    assign ex_y = data_y;

    // ==============================
    // Operand snoop
    // ==============================
    always_comb begin
        if (accept) begin
            next_x = branch_pkg::capture_operand(iss_tag_x, iss_data_x, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
            next_y = branch_pkg::capture_operand(iss_tag_y, iss_data_y, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
        end else begin
            next_x = branch_pkg::capture_operand(tag_x, data_x, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
            next_y = branch_pkg::capture_operand(tag_y, data_y, alu0_valid, alu0_data,
                                                 alu1_valid, alu1_data, ls_valid, ls_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (release_entry) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pc  <= iss_pc;
            ex_op  <= iss_op;
            ex_imm <= iss_imm;
        end
        {tag_x, data_x} <= next_x; // Snoop every cycle
        {tag_y, data_y} <= next_y;
    end

endmodule

/* verilog/branch_resolve.sv */
module branch_resolve (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ex_valid,
    output logic                            ex_ready,
    input  logic [branch_pkg::word_w-1:0]   ex_pc,
    input  logic [branch_pkg::op_w-1:0]     ex_op,
    input  logic [branch_pkg::word_w-1:0]   ex_imm,
    input  logic [branch_pkg::word_w-1:0]   ex_x,
    input  logic [branch_pkg::word_w-1:0]   ex_y,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [branch_pkg::word_w-1:0]   out_pc,
    output logic                            out_taken,
    output logic [branch_pkg::word_w-1:0]   out_target,
    output logic [branch_pkg::word_w-1:0]   out_link
);

    logic                            accept;
    logic                            eq;
    logic                            lt_s;
    logic                            lt_u;
    logic                            taken;
    logic [branch_pkg::word_w-1:0]   link;
    logic [branch_pkg::word_w-1:0]   pc_rel;
    logic [branch_pkg::word_w-1:0]   reg_rel;
    logic [branch_pkg::word_w-1:0]   target;

    assign ex_ready = !out_valid || out_ready;
    assign accept   = ex_valid && ex_ready;

    // ==============================
    // Condition and target
    // ==============================
    assign eq   = (ex_x == ex_y);
    assign lt_s = ($signed(ex_x) < $signed(ex_y));
    assign lt_u = (ex_x < ex_y);

    assign link    = ex_pc + branch_pkg::inst_bytes;
    assign pc_rel  = ex_pc + ex_imm;
    assign reg_rel = (ex_x + ex_imm) & ~32'd1; // Bit 0 cleared for jalr

    always_comb begin
        case (ex_op)
            branch_pkg::op_beq:  taken = eq;
            branch_pkg::op_bne:  taken = !eq;
            branch_pkg::op_blt:  taken = lt_s;
            branch_pkg::op_bge:  taken = !lt_s;
            branch_pkg::op_bltu: taken = lt_u;
            branch_pkg::op_bgeu: taken = !lt_u;
            branch_pkg::op_jal:  taken = 1'b1;
            branch_pkg::op_jalr: taken = 1'b1;
            default:             taken = 1'b0; // Unknown code falls through
        endcase
    end

    always_comb begin
        if (ex_op == branch_pkg::op_jalr) begin
            target = reg_rel;
        end else if (taken) begin
            target = pc_rel;
        end else begin
            target = link; // Next sequential PC
        end
    end

    // ==============================
    // Redirect register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Held under back-pressure since accept needs ex_ready
    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc     <= ex_pc;
            out_taken  <= taken;
            out_target <= target;
            out_link   <= link;
        end
    end

endmodule

/* verilog/branch_top.sv */
module branch_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [branch_pkg::word_w-1:0]   in_pc,
    input  logic [branch_pkg::op_w-1:0]     in_op,
    input  logic [branch_pkg::word_w-1:0]   in_imm,
    input  logic [branch_pkg::tag_w-1:0]    in_tag_x,
    input  logic [branch_pkg::tag_w-1:0]    in_tag_y,
    input  logic [branch_pkg::word_w-1:0]   in_data_x,
    input  logic [branch_pkg::word_w-1:0]   in_data_y,
    input  logic                            alu0_valid,
    input  logic [branch_pkg::word_w-1:0]   alu0_data,
    input  logic                            alu1_valid,
    input  logic [branch_pkg::word_w-1:0]   alu1_data,
    input  logic                            ls_valid,
    input  logic [branch_pkg::word_w-1:0]   ls_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [branch_pkg::word_w-1:0]   out_pc,
    output logic                            out_taken,
    output logic [branch_pkg::word_w-1:0]   out_target,
    output logic [branch_pkg::word_w-1:0]   out_link
);

    // Issue to station
    logic                            iss_valid;
    logic                            iss_ready;
    logic [branch_pkg::word_w-1:0]   iss_pc;
    logic [branch_pkg::op_w-1:0]     iss_op;
    logic [branch_pkg::word_w-1:0]   iss_imm;
    logic [branch_pkg::tag_w-1:0]    iss_tag_x;
    logic [branch_pkg::tag_w-1:0]    iss_tag_y;
    logic [branch_pkg::word_w-1:0]   iss_data_x;
    logic [branch_pkg::word_w-1:0]   iss_data_y;

    // Station to resolve
    logic                            ex_valid;
    logic                            ex_ready;
    logic [branch_pkg::word_w-1:0]   ex_pc;
    logic [branch_pkg::op_w-1:0]     ex_op;
    logic [branch_pkg::word_w-1:0]   ex_imm;
    logic [branch_pkg::word_w-1:0]   ex_x;
    logic [branch_pkg::word_w-1:0]   ex_y;

    branch_issue_stage u_issue (
        .clk, .rst,
        .in_valid, .in_ready, .in_pc, .in_op, .in_imm,
        .in_tag_x, .in_tag_y, .in_data_x, .in_data_y,
        .alu0_valid, .alu0_data, .alu1_valid, .alu1_data, .ls_valid, .ls_data,
        .iss_valid, .iss_ready, .iss_pc, .iss_op, .iss_imm,
        .iss_tag_x, .iss_tag_y, .iss_data_x, .iss_data_y
    );

    branch_station u_station (
        .clk, .rst,
        .iss_valid, .iss_ready, .iss_pc, .iss_op, .iss_imm,
        .iss_tag_x, .iss_tag_y, .iss_data_x, .iss_data_y,
        .alu0_valid, .alu0_data, .alu1_valid, .alu1_data, .ls_valid, .ls_data,
        .ex_valid, .ex_ready, .ex_pc, .ex_op, .ex_imm, .ex_x, .ex_y
    );

    branch_resolve u_resolve (
        .clk, .rst,
        .ex_valid, .ex_ready, .ex_pc, .ex_op, .ex_imm, .ex_x, .ex_y,
        .out_valid, .out_ready, .out_pc, .out_taken, .out_target, .out_link
    );

endmodule

/* sim/branch_tb.sv */
module branch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_directed   = 4;
    localparam int n_random     = 200;
    localparam int limit_cycles = n_directed * 200 + n_random * 50;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    logic [3:0]  in_op;
    logic [31:0] in_imm;
    logic [1:0]  in_tag_x;
    logic [1:0]  in_tag_y;
    logic [31:0] in_data_x;
    logic [31:0] in_data_y;
    logic        alu0_valid;
    logic [31:0] alu0_data;
    logic        alu1_valid;
    logic [31:0] alu1_data;
    logic        ls_valid;
    logic [31:0] ls_data;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_pc;
    logic        out_taken;
    logic [31:0] out_target;
    logic [31:0] out_link;

    // Branches accepted but not yet out, oldest first
    logic [31:0] m_pc[$];
    logic [3:0]  m_op[$];
    logic [31:0] m_imm[$];
    logic [1:0]  m_tx[$];
    logic [1:0]  m_ty[$];
    logic [31:0] m_x[$];
    logic [31:0] m_y[$];

    int n_in = 0;
    int n_out = 0;
    int n_checks = 0;
    int n_errors = 0;
    bit stream_done;

    branch_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    // ==============================
    // Checking and reference model
    // ==============================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    function automatic logic model_taken(input logic [3:0] op, input logic [31:0] x,
                                         input logic [31:0] y);
        logic [31:0] xs;
        logic [31:0] ys;
        xs = x ^ 32'h8000_0000; // Sign flip turns signed order into unsigned order
        ys = y ^ 32'h8000_0000;
        case (op)
            branch_pkg::op_beq:  return x == y;
            branch_pkg::op_bne:  return x != y;
            branch_pkg::op_blt:  return xs < ys;
            branch_pkg::op_bge:  return xs >= ys;
            branch_pkg::op_bltu: return x < y;
            branch_pkg::op_bgeu: return x >= y;
            branch_pkg::op_jal:  return 1'b1;
            branch_pkg::op_jalr: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_target(input logic [3:0] op, input logic [31:0] pc,
                                                 input logic [31:0] imm, input logic [31:0] x,
                                                 input logic [31:0] y);
        logic [31:0] sum;
        if (op == branch_pkg::op_jalr) begin
            sum = x + imm;
            return {sum[31:1], 1'b0};
        end
        if (model_taken(op, x, y)) begin
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    function automatic logic bus_hit(input logic [1:0] tag);
        case (tag)
            branch_pkg::tag_alu0: return alu0_valid;
            branch_pkg::tag_alu1: return alu1_valid;
            branch_pkg::tag_ls:   return ls_valid;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] bus_data(input logic [1:0] tag);
        case (tag)
            branch_pkg::tag_alu0: return alu0_data;
            branch_pkg::tag_alu1: return alu1_data;
            default:              return ls_data;
        endcase
    endfunction

    // Inputs are driven at the falling edge, so they are stable here
    task automatic monitor_loop();
        int i;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (out_valid && out_ready) begin
                    if (m_pc.size() == 0) begin
                        $display("ERROR t=%0t a result came out with no branch in flight", $time);
                        n_errors++;
                    end else begin
                        if (m_tx[0] != branch_pkg::tag_unlocked ||
                            m_ty[0] != branch_pkg::tag_unlocked) begin
                            $display("ERROR t=%0t branch resolved before its operands arrived",
                                     $time);
                            n_errors++;
                        end
                        check_value("out_pc", out_pc, m_pc[0]);
                        check_value("out_taken", 32'(out_taken),
                                    32'(model_taken(m_op[0], m_x[0], m_y[0])));
                        check_value("out_target", out_target,
                                    model_target(m_op[0], m_pc[0], m_imm[0], m_x[0], m_y[0]));
                        check_value("out_link", out_link, m_pc[0] + 32'd4);
                        m_pc.delete(0);
                        m_op.delete(0);
                        m_imm.delete(0);
                        m_tx.delete(0);
                        m_ty.delete(0);
                        m_x.delete(0);
                        m_y.delete(0);
                    end
                    n_out++;
                end
                if (in_valid && in_ready) begin
                    m_pc.push_back(in_pc);
                    m_op.push_back(in_op);
                    m_imm.push_back(in_imm);
                    m_tx.push_back(in_tag_x);
                    m_ty.push_back(in_tag_y);
                    m_x.push_back(in_data_x);
                    m_y.push_back(in_data_y);
                    n_in++;
                end
                for (i = 0; i < m_pc.size(); i++) begin // Every waiting operand snoops
                    if (bus_hit(m_tx[i])) begin
                        m_x[i] = bus_data(m_tx[i]);
                        m_tx[i] = branch_pkg::tag_unlocked;
                    end
                    if (bus_hit(m_ty[i])) begin
                        m_y[i] = bus_data(m_ty[i]);
                        m_ty[i] = branch_pkg::tag_unlocked;
                    end
                end
            end
        end
    endtask

    // ==============================
    // Drivers
    // ==============================
    task automatic issue(input logic [31:0] pc, input logic [3:0] op, input logic [31:0] imm,
                         input logic [1:0] tx, input logic [1:0] ty,
                         input logic [31:0] dx, input logic [31:0] dy);
        int start;
        start = n_in;
        in_pc = pc;
        in_op = op;
        in_imm = imm;
        in_tag_x = tx;
        in_tag_y = ty;
        in_data_x = dx;
        in_data_y = dy;
        in_valid = 1'b1;
        while (n_in == start) @(negedge clk); // Until the DUT takes it
        in_valid = 1'b0;
    endtask

    task automatic clear_buses();
        alu0_valid = 1'b0;
        alu1_valid = 1'b0;
        ls_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [1:0] unit, input logic [31:0] data);
        case (unit)
            branch_pkg::tag_alu0: begin
                alu0_valid = 1'b1;
                alu0_data = data;
            end
            branch_pkg::tag_alu1: begin
                alu1_valid = 1'b1;
                alu1_data = data;
            end
            default: begin
                ls_valid = 1'b1;
                ls_data = data;
            end
        endcase
        @(negedge clk);
        clear_buses();
    endtask

    // Counts clock edges from the in transfer until out_valid shows
    task automatic measure_latency(input int exp);
        int count;
        count = 1;
        while (!out_valid && count < 12) begin
            @(negedge clk);
            clear_buses();
            count++;
        end
        if (!out_valid) begin
            $display("ERROR t=%0t no result appeared within 12 cycles", $time);
            n_errors++;
        end else begin
            check_value("latency", count, exp);
        end
    endtask

    task automatic wait_drain();
        while (n_out != n_in) @(negedge clk);
    endtask

    task automatic resolve_case(input logic [31:0] pc, input logic [3:0] op,
                                input logic [31:0] imm, input logic [31:0] x,
                                input logic [31:0] y);
        issue(pc, op, imm, branch_pkg::tag_unlocked, branch_pkg::tag_unlocked, x, y);
        measure_latency(3);
        wait_drain();
    endtask

    task automatic issue_random();
        logic [31:0] x;
        logic [31:0] y;
        x = $urandom;
        y = ($urandom_range(0, 3) == 0) ? x : $urandom; // Equal operands now and then
        issue($urandom, 4'($urandom_range(0, 8)), $urandom, 2'($urandom_range(0, 3)),
              2'($urandom_range(0, 3)), x, y);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("Test %s done, %0d errors", name, n_errors - errors_before);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_ops();
        int e0;
        e0 = n_errors;
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);
        resolve_case(32'h100, branch_pkg::op_beq, 32'h20, 32'd7, 32'd7);
        resolve_case(32'h104, branch_pkg::op_bne, 32'h20, 32'd7, 32'd7);
        resolve_case(32'h108, branch_pkg::op_blt, 32'h40, 32'hFFFF_FFFF, 32'd1);
        resolve_case(32'h10C, branch_pkg::op_bltu, 32'h40, 32'hFFFF_FFFF, 32'd1);
        resolve_case(32'h110, branch_pkg::op_bge, 32'h80, 32'h8000_0000, 32'h7FFF_FFFF);
        resolve_case(32'h114, branch_pkg::op_bgeu, 32'h80, 32'h8000_0000, 32'h7FFF_FFFF);
        resolve_case(32'h118, branch_pkg::op_jal, 32'hFFFF_FF00, 32'd0, 32'd0);
        resolve_case(32'h11C, branch_pkg::op_jalr, 32'd2, 32'h0000_1001, 32'd0);
        resolve_case(32'h120, 4'hF, 32'h40, 32'd1, 32'd1);
        finish_test("1 resolve ops", e0);
    endtask

    task automatic test_tags();
        int e0;
        e0 = n_errors;
        issue(32'h200, branch_pkg::op_blt, 32'h40, branch_pkg::tag_alu0, branch_pkg::tag_ls,
              32'd0, 32'd0);
        broadcast(branch_pkg::tag_alu1, 32'h7777_0000);
        broadcast(branch_pkg::tag_alu0, 32'hFFFF_FFF0);
        broadcast(branch_pkg::tag_alu0, 32'd5); // x already captured
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
        end
        broadcast(branch_pkg::tag_ls, 32'd3);
        wait_drain();
        finish_test("2 tag wakeup", e0);
    endtask

    task automatic test_same_cycle();
        int e0;
        e0 = n_errors;
        alu1_valid = 1'b1;
        alu1_data = 32'h1234;
        issue(32'h300, branch_pkg::op_beq, 32'h10, branch_pkg::tag_alu1,
              branch_pkg::tag_unlocked, 32'd0, 32'h1234);
        clear_buses();
        measure_latency(3);
        wait_drain();
        issue(32'h340, branch_pkg::op_bne, 32'h10, branch_pkg::tag_unlocked,
              branch_pkg::tag_ls, 32'd9, 32'd0);
        ls_valid = 1'b1; // On the issue to station edge
        ls_data = 32'd9;
        measure_latency(3);
        wait_drain();
        finish_test("3 same cycle", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = n_errors;
        out_ready = 1'b0;
        issue(32'h400, branch_pkg::op_jal, 32'h100, 2'd0, 2'd0, 32'd0, 32'd0);
        issue(32'h404, branch_pkg::op_bne, 32'h20, 2'd0, 2'd0, 32'd1, 32'd2);
        issue(32'h408, branch_pkg::op_bgeu, 32'h30, 2'd0, 2'd0, 32'd1, 32'd2);
        repeat (4) begin
            check_value("in_ready", 32'(in_ready), 32'd0);
            check_value("out_valid", 32'(out_valid), 32'd1);
            check_value("out_pc", out_pc, 32'h400);
            check_value("out_taken", 32'(out_taken), 32'd1);
            check_value("out_target", out_target, 32'h500); // jal lands at pc plus imm
            check_value("out_link", out_link, 32'h404);
            @(negedge clk);
        end
        out_ready = 1'b1;
        wait_drain();
        finish_test("4 back-pressure", e0);
    endtask

    task automatic test_random();
        int e0;
        int k;
        e0 = n_errors;
        stream_done = 1'b0;
        fork
            begin
                for (k = 0; k < n_random; k++) begin
                    repeat ($urandom_range(0, 2)) @(negedge clk);
                    issue_random();
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done || n_out != n_in) begin
                    @(negedge clk);
                    alu0_valid = ($urandom_range(0, 3) == 0);
                    alu0_data = $urandom;
                    alu1_valid = ($urandom_range(0, 3) == 0);
                    alu1_data = $urandom;
                    ls_valid = ($urandom_range(0, 3) == 0);
                    ls_data = $urandom;
                    out_ready = ($urandom_range(0, 3) != 0);
                end
            end
        join
        clear_buses();
        out_ready = 1'b1;
        wait_drain();
        finish_test("5 random stream", e0);
    endtask

    initial begin
        void'($urandom(32'h48ce_0b68));
        rst = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_op = '0;
        in_imm = '0;
        in_tag_x = '0;
        in_tag_y = '0;
        in_data_x = '0;
        in_data_y = '0;
        alu0_valid = 1'b0;
        alu0_data = '0;
        alu1_valid = 1'b0;
        alu1_data = '0;
        ls_valid = 1'b0;
        ls_data = '0;
        out_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        fork
            monitor_loop();
        join_none
        test_ops();
        test_tags();
        test_same_cycle();
        test_backpressure();
        test_random();
        $display("Tests finished: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/branch_pkg.sv
verilog/branch_issue_stage.sv
verilog/branch_station.sv
verilog/branch_resolve.sv
verilog/branch_top.sv
sim/branch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module branch_tb -f compile.f -o branch_sim

./obj_dir/branch_sim > sim.log
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
